// ==== verilog/ieuCtrl_defs.svh ====
`ifndef IEU_CTRL_DEFS_SVH
`define IEU_CTRL_DEFS_SVH

// Datapath widths
`define REGW     5   // Register index
`define INSTRW   32  // Instruction word
`define IMMSRCW  3   // Immediate format select
`define RESSRCW  3   // Writeback result source
`define FWDW     2   // Forwarding mux select

// Main decoder control word
// {RegWrite, ImmSrc[2:0], ALUSrcA, ALUSrcB, MemRW[1:0], ResultSrc[2:0],
//  Branch, ALUOp, Jump, Privileged, Fence, Illegal}
`define CTRLW    17

// Instruction field positions
`define OP_LSB   0   // Opcode [6:0]
`define RD_LSB   7   // rd [11:7]
`define F3_LSB   12  // funct3 [14:12]
`define RS1_LSB  15  // rs1 [19:15]
`define RS2_LSB  20  // rs2 [24:20]
`define F7_LSB   25  // funct7 [31:25]

`endif

// ==== verilog/ieuCtrlPkg.sv ====
`default_nettype none

`include "ieuCtrl_defs.svh"

package ieuCtrlPkg;

  // Major opcodes handled by the integer unit
  typedef enum logic [6:0] {
    opLoad   = 7'b0000011,
    opFence  = 7'b0001111,
    opImm    = 7'b0010011,
    opAuipc  = 7'b0010111,
    opStore  = 7'b0100011,
    opReg    = 7'b0110011,  // R-type and M extension
    opLui    = 7'b0110111,
    opBranch = 7'b1100011,
    opJalr   = 7'b1100111,
    opJal    = 7'b1101111,
    opSystem = 7'b1110011   // Zicsr and privileged
  } opcodeE;

  typedef enum logic [`RESSRCW-1:0] {
    resAlu = 3'd0,  // ALU or address result
    resMem = 3'd1,  // Load data
    resCsr = 3'd2,  // CSR read data
    resMdu = 3'd3   // Multiply/divide unit
  } resultSrcE;

  typedef enum logic [`IMMSRCW-1:0] {
    immI = 3'd0,
    immS = 3'd1,
    immB = 3'd2,
    immJ = 3'd3,
    immU = 3'd4
  } immSrcE;

  typedef enum logic [`FWDW-1:0] {
    fwdNone = 2'b00,  // Register file value
    fwdW    = 2'b01,  // Writeback result
    fwdM    = 2'b10   // Memory stage result
  } fwdSelE;

endpackage

`default_nettype wire

// ==== verilog/instrDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ieuCtrl_defs.svh"

module instrDecoder import ieuCtrlPkg::*; (
  input  logic [`INSTRW-1:0] InstrD,            // Instruction in Decode
  input  logic               IllegalIEUInstrD,  // Squash from earlier decode
  output logic [`REGW-1:0]   Rs1D, Rs2D, RdD,   // Register fields
  output logic [2:0]         Funct3D,
  output logic [6:0]         Funct7D,
  output immSrcE             ImmSrcD,           // Immediate format
  output logic               RegWriteD,
  output logic               ALUSrcAD, ALUSrcBD,
  output logic [1:0]         MemRWD,            // {read, write}
  output resultSrcE          ResultSrcD,
  output logic               BranchD, JumpD,
  output logic               ALUResultSrcD,
  output logic [2:0]         ALUSelectD,
  output logic               SubArithD,         // sub, sra, slt, sltu
  output logic               MDUD,
  output logic               CSRReadD, CSRWriteD,
  output logic               PrivilegedD,
  output logic               FenceD,            // fence, fence.i or sfence.vma
  output logic               InvalidateICacheD,
  output logic               IllegalBaseInstrD
);

  opcodeE            OpD;
  logic              funct7ZeroD, funct7b5D;
  logic              iFunctD, rFunctD, mFunctD, lFunctD, sFunctD, bFunctD;
  logic              jrFunctD, fenceFunctD, pFunctD, csrFunctD;
  logic [`CTRLW-1:0] ControlsD, squashedD;
  logic [2:0]        immRawD, resRawD;
  logic              ALUOpD, FenceXD, sFenceVmaD;
  logic              subD, sraD, sltD, sltuD;

  // Illegal word: no register write, no memory access, illegal bit set
  localparam logic [`CTRLW-1:0] illegalCtrl = {1'b0, immI, 2'b00, 2'b00, resAlu, 5'b00000, 1'b1};

  assign OpD     = opcodeE'(InstrD[`OP_LSB +: 7]);
  assign RdD     = InstrD[`RD_LSB +: `REGW];
  assign Rs1D    = InstrD[`RS1_LSB +: `REGW];
  assign Rs2D    = InstrD[`RS2_LSB +: `REGW];
  assign Funct3D = InstrD[`F3_LSB +: 3];
  assign Funct7D = InstrD[`F7_LSB +: 7];

  //////////////////////////////////////////////////////////////////////
  // Strict legality by opcode class

  assign funct7ZeroD = (Funct7D == 7'b0000000);
  assign funct7b5D   = (Funct7D == 7'b0100000);                  // sub, sra, srai
  assign iFunctD     = (Funct3D == 3'b001) ? funct7ZeroD :         // slli
                       (Funct3D == 3'b101) ? (funct7ZeroD | funct7b5D) : 1'b1;
  assign rFunctD     = funct7ZeroD | (funct7b5D & (Funct3D == 3'b000 | Funct3D == 3'b101));
  assign mFunctD     = (Funct7D == 7'b0000001);                  // Any funct3 is a valid M op
  assign lFunctD     = (Funct3D != 3'b011) & (Funct3D[2:1] != 2'b11); // lb lh lw lbu lhu
  assign sFunctD     = (Funct3D == 3'b000 | Funct3D == 3'b001 | Funct3D == 3'b010);
  assign bFunctD     = (Funct3D[2:1] != 2'b01);                  // 010 and 011 reserved
  assign jrFunctD    = (Funct3D == 3'b000);
  assign fenceFunctD = (Funct3D == 3'b000 | Funct3D == 3'b001);  // fence, fence.i
  assign pFunctD     = (Funct3D == 3'b000) & (RdD == '0);        // ecall, mret, wfi, sfence.vma
  assign csrFunctD   = (Funct3D[1:0] != 2'b00);

  //////////////////////////////////////////////////////////////////////
  // Main decoder

  always_comb begin
    ControlsD = illegalCtrl;
    // RegWrite ImmSrc SrcA/B MemRW ResultSrc Branch ALUOp Jump Priv Fence Illegal
    case (OpD)
      opLoad:   if (lFunctD)     ControlsD = {1'b1, immI, 2'b01, 2'b10, resMem, 6'b000000};
      opFence:  if (fenceFunctD) ControlsD = {1'b0, immI, 2'b00, 2'b00, resAlu, 6'b000010};
      opImm:    if (iFunctD)     ControlsD = {1'b1, immI, 2'b01, 2'b00, resAlu, 6'b010000};
      opAuipc:                   ControlsD = {1'b1, immU, 2'b11, 2'b00, resAlu, 6'b000000};
      opStore:  if (sFunctD)     ControlsD = {1'b0, immS, 2'b01, 2'b01, resAlu, 6'b000000};
      opReg:    if (rFunctD)     ControlsD = {1'b1, immI, 2'b00, 2'b00, resAlu, 6'b010000};
                else if (mFunctD) ControlsD = {1'b1, immI, 2'b00, 2'b00, resMdu, 6'b000000};
      opLui:                     ControlsD = {1'b1, immU, 2'b01, 2'b00, resAlu, 6'b000000};
      opBranch: if (bFunctD)     ControlsD = {1'b0, immB, 2'b11, 2'b00, resAlu, 6'b100000};
      opJalr:   if (jrFunctD)    ControlsD = {1'b1, immI, 2'b01, 2'b00, resAlu, 6'b001000};
      opJal:                     ControlsD = {1'b1, immJ, 2'b11, 2'b00, resAlu, 6'b001000};
      opSystem: if (pFunctD)     ControlsD = {1'b0, immI, 2'b00, 2'b00, resAlu, 6'b000100};
                else if (csrFunctD) ControlsD = {1'b1, immI, 2'b00, 2'b00, resCsr, 6'b000000};
      default: ;                                                // Unknown opcode stays illegal
    endcase
  end

  assign squashedD = IllegalIEUInstrD ? '0 : ControlsD;         // Drop all controls
  assign {RegWriteD, immRawD, ALUSrcAD, ALUSrcBD, MemRWD, resRawD,
          BranchD, ALUOpD, JumpD, PrivilegedD, FenceXD} = squashedD[`CTRLW-1:1];
  assign ImmSrcD           = immSrcE'(immRawD);
  assign ResultSrcD        = resultSrcE'(resRawD);
  assign IllegalBaseInstrD = squashedD[0];

  // lui and jumps pass the B operand or link address straight through
  assign ALUResultSrcD = JumpD | ((ImmSrcD == immU) & ~ALUSrcAD);
  assign MDUD          = (ResultSrcD == resMdu);
  assign CSRReadD      = (ResultSrcD == resCsr);

  //////////////////////////////////////////////////////////////////////
  // CSR, fences and ALU op

  assign CSRWriteD         = CSRReadD & ~(Funct3D[1] & (Rs1D == '0)); // set/clear with zero
  assign sFenceVmaD        = PrivilegedD & (Funct7D == 7'b0001001);
  assign FenceD            = FenceXD | sFenceVmaD;
  assign InvalidateICacheD = FenceXD & (Funct3D == 3'b001);   // fence.i

  assign subD  = (Funct3D == 3'b000) & Funct7D[5] & InstrD[`OP_LSB + 5]; // Not addi
  assign sraD  = (Funct3D == 3'b101) & Funct7D[5];
  assign sltD  = (Funct3D == 3'b010);
  assign sltuD = (Funct3D == 3'b011);
  assign SubArithD  = ALUOpD & (subD | sraD | sltD | sltuD);
  assign ALUSelectD = ALUOpD ? Funct3D : 3'b000;               // Add for address generation

endmodule

`default_nettype wire

// ==== verilog/ctrlPipe.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ieuCtrl_defs.svh"

module ctrlPipe import ieuCtrlPkg::*; (
  input  logic             clk, rstN,
  input  logic             StallD, StallE, StallM, StallW,
  input  logic             FlushD, FlushE, FlushM, FlushW,
  input  logic [1:0]       FlagsE,                      // {eq, lt}
  input  logic [`REGW-1:0] Rs1D, Rs2D, RdD,
  input  logic [2:0]       Funct3D,
  input  logic [6:0]       Funct7D,
  input  logic             RegWriteD, ALUSrcAD, ALUSrcBD,
  input  logic [1:0]       MemRWD,
  input  resultSrcE        ResultSrcD,
  input  logic             BranchD, JumpD, ALUResultSrcD,
  input  logic [2:0]       ALUSelectD,
  input  logic             SubArithD, MDUD, CSRReadD, CSRWriteD,
  input  logic             PrivilegedD, FenceD, InvalidateICacheD,
  output logic             InstrValidD, InstrValidE, InstrValidM,
  output logic [`REGW-1:0] Rs1E, Rs2E, RdE, RdM, RdW,
  output logic             PCSrcE,
  output logic             ALUSrcAE, ALUSrcBE, ALUResultSrcE,
  output logic [2:0]       ALUSelectE, Funct3E,
  output logic [6:0]       Funct7E,
  output logic             SubArithE, BranchE, JumpE, BranchSignedE,
  output logic             MDUActiveE, IntDivE,
  output resultSrcE        ResultSrcE,
  output logic [1:0]       MemRWE, MemRWM,
  output logic             CSRReadE, CSRReadM, CSRWriteM, PrivilegedM,
  output logic [2:0]       Funct3M,
  output logic             InvalidateICacheM, FlushDCacheM, CSRWriteFenceM,
  output logic             RegWriteM, RegWriteW,
  output resultSrcE        ResultSrcW,
  output logic             IntDivW
);

  localparam int EW = 32 + 3 * `REGW;  // Execute register width
  localparam int MW = 16 + `REGW;      // Memory register width
  localparam int WW = 5 + `REGW;       // Writeback register width

  logic [EW-1:0] nextE, regE;
  logic [MW-1:0] nextM, regM;
  logic [WW-1:0] nextW, regW;
  logic [2:0]    resRawE, resRawM, resRawW;
  logic          RegWriteE, CSRWriteE, PrivilegedE, MDUE;
  logic          InvalidateICacheE, FenceE, FenceM, IntDivM;
  logic          branchFlagE, branchTakenE;

  always_ff @(posedge clk) begin
    if (!rstN || FlushD) InstrValidD <= 1'b0;
    else if (!StallD)    InstrValidD <= 1'b1;              // Fetch delivers every cycle
  end

  //////////////////////////////////////////////////////////////////////
  // Execute stage

  assign nextE = {ALUSelectD, RegWriteD, ResultSrcD, MemRWD, JumpD, BranchD, ALUSrcAD, ALUSrcBD,
                  ALUResultSrcD, CSRReadD, CSRWriteD, PrivilegedD, Funct3D, Funct7D, SubArithD,
                  MDUD, InvalidateICacheD, FenceD, InstrValidD, Rs1D, Rs2D, RdD};

  always_ff @(posedge clk) begin
    if (!rstN || FlushE) regE <= '0;                       // Flush wins over stall
    else if (!StallE)    regE <= nextE;
  end

  assign {ALUSelectE, RegWriteE, resRawE, MemRWE, JumpE, BranchE, ALUSrcAE, ALUSrcBE,
          ALUResultSrcE, CSRReadE, CSRWriteE, PrivilegedE, Funct3E, Funct7E, SubArithE,
          MDUE, InvalidateICacheE, FenceE, InstrValidE, Rs1E, Rs2E, RdE} = regE;
  assign ResultSrcE = resultSrcE'(resRawE);

  // Comparator gives eq and lt, signedness chosen by BranchSignedE
  assign branchFlagE   = Funct3E[2] ? FlagsE[0] : FlagsE[1];  // blt/bge family uses lt
  assign branchTakenE  = branchFlagE ^ Funct3E[0];            // bne, bge, bgeu invert
  assign PCSrcE        = JumpE | (BranchE & branchTakenE);
  assign BranchSignedE = BranchE & (Funct3E[2:1] != 2'b11);
  assign MDUActiveE    = (ResultSrcE == resMdu);
  assign IntDivE       = MDUE & Funct3E[2];                   // div, divu, rem, remu

  //////////////////////////////////////////////////////////////////////
  // Memory and Writeback stages

  assign nextM = {RegWriteE, resRawE, MemRWE, CSRReadE, CSRWriteE, PrivilegedE, Funct3E,
                  InvalidateICacheE, FenceE, InstrValidE, IntDivE, RdE};

  always_ff @(posedge clk) begin
    if (!rstN || FlushM) regM <= '0;
    else if (!StallM)    regM <= nextM;
  end

  assign {RegWriteM, resRawM, MemRWM, CSRReadM, CSRWriteM, PrivilegedM, Funct3M,
          InvalidateICacheM, FenceM, InstrValidM, IntDivM, RdM} = regM;
  assign FlushDCacheM   = InvalidateICacheM;                  // fence.i also writes back D$
  assign CSRWriteFenceM = CSRWriteM | FenceM;                 // Younger stages must refetch

  assign nextW = {RegWriteM, resRawM, IntDivM, RdM};

  always_ff @(posedge clk) begin
    if (!rstN || FlushW) regW <= '0;
    else if (!StallW)    regW <= nextW;
  end

  assign {RegWriteW, resRawW, IntDivW, RdW} = regW;
  assign ResultSrcW = resultSrcE'(resRawW);

endmodule

`default_nettype wire

// ==== verilog/hazardUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ieuCtrl_defs.svh"

module hazardUnit import ieuCtrlPkg::*; (
  input  logic [`REGW-1:0] Rs1D, Rs2D,        // Decode sources
  input  logic [1:0]       MemRWD,            // {read, write} in Decode
  input  logic [`REGW-1:0] Rs1E, Rs2E, RdE,   // Execute registers
  input  logic [`REGW-1:0] RdM, RdW,
  input  logic             RegWriteM, RegWriteW,
  input  logic [1:0]       MemRWE,
  input  resultSrcE        ResultSrcE,
  input  logic             CSRReadE,
  output fwdSelE           ForwardAE, ForwardBE,
  output logic             LoadStallD,        // Load-use, also to perf counters
  output logic             StoreStallD,       // Load right after a store
  output logic             StructuralStallD
);

  logic matchDE;                              // Decode source needs the Execute result
  logic csrRdStallD, mduStallD;

  // Memory result is newer than Writeback, so it wins
  function automatic fwdSelE pickFwd(input logic [`REGW-1:0] rs);
    fwdSelE sel;
    sel = fwdNone;
    if (rs != '0) begin                       // x0 is never forwarded
      if (RegWriteM && (rs == RdM))      sel = fwdM;
      else if (RegWriteW && (rs == RdW)) sel = fwdW;
    end
    return sel;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Forwarding into the Execute operands

  always_comb begin
    ForwardAE = pickFwd(Rs1E);
    ForwardBE = pickFwd(Rs2E);
  end

  //////////////////////////////////////////////////////////////////////
  // Structural stalls in Decode

  assign matchDE = ((Rs1D == RdE) | (Rs2D == RdE)) & (RdE != '0);

  assign LoadStallD  = MemRWE[1] & matchDE;             // Load data only ready in Memory
  assign StoreStallD = MemRWD[1] & MemRWE[0];           // Store then load
  assign csrRdStallD = CSRReadE & matchDE;              // CSR data read in Memory
  assign mduStallD   = (ResultSrcE == resMdu) & matchDE; // Multi-cycle mul/div

  assign StructuralStallD = LoadStallD | StoreStallD | csrRdStallD | mduStallD;

endmodule

`default_nettype wire

// ==== verilog/ieuController.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ieuCtrl_defs.svh"

module ieuController import ieuCtrlPkg::*; (
  input  logic               clk, rstN,
  input  logic [`INSTRW-1:0] InstrD,
  input  logic               IllegalIEUInstrD,
  input  logic               StallD, StallE, StallM, StallW,
  input  logic               FlushD, FlushE, FlushM, FlushW,
  input  logic [1:0]         FlagsE,                     // {eq, lt}
  // Decode
  output immSrcE             ImmSrcD,
  output logic               JumpD, BranchD, IllegalBaseInstrD,
  output logic [`REGW-1:0]   Rs1D, Rs2D,
  output logic               LoadStallD, StoreStallD, StructuralStallD,
  output logic               InstrValidD,
  // Execute
  output logic [`REGW-1:0]   Rs1E, Rs2E, RdE,
  output logic               PCSrcE, ALUSrcAE, ALUSrcBE, ALUResultSrcE,
  output logic [2:0]         ALUSelectE, Funct3E,
  output logic [6:0]         Funct7E,
  output logic               SubArithE, BranchE, JumpE, BranchSignedE,
  output logic               MDUActiveE, IntDivE, CSRReadE, InstrValidE,
  output resultSrcE          ResultSrcE,
  output logic [1:0]         MemRWE,
  output fwdSelE             ForwardAE, ForwardBE,
  // Memory
  output logic [`REGW-1:0]   RdM,
  output logic [1:0]         MemRWM,
  output logic               CSRReadM, CSRWriteM, PrivilegedM, InstrValidM,
  output logic [2:0]         Funct3M,
  output logic               InvalidateICacheM, FlushDCacheM, CSRWriteFenceM, RegWriteM,
  // Writeback
  output logic [`REGW-1:0]   RdW,
  output logic               RegWriteW, IntDivW,
  output resultSrcE          ResultSrcW
);

  // Decode controls heading into the pipe
  logic [`REGW-1:0] RdD;
  logic [2:0]       Funct3D, ALUSelectD;
  logic [6:0]       Funct7D;
  logic [1:0]       MemRWD;
  resultSrcE        ResultSrcD;
  logic             RegWriteD, ALUSrcAD, ALUSrcBD, ALUResultSrcD, SubArithD, MDUD;
  logic             CSRReadD, CSRWriteD, PrivilegedD, FenceD, InvalidateICacheD;

  instrDecoder decoder (
    .InstrD, .IllegalIEUInstrD, .Rs1D, .Rs2D, .RdD, .Funct3D, .Funct7D, .ImmSrcD,
    .RegWriteD, .ALUSrcAD, .ALUSrcBD, .MemRWD, .ResultSrcD, .BranchD, .JumpD,
    .ALUResultSrcD, .ALUSelectD, .SubArithD, .MDUD, .CSRReadD, .CSRWriteD,
    .PrivilegedD, .FenceD, .InvalidateICacheD, .IllegalBaseInstrD
  );

  ctrlPipe pipe (
    .clk, .rstN, .StallD, .StallE, .StallM, .StallW, .FlushD, .FlushE, .FlushM, .FlushW,
    .FlagsE, .Rs1D, .Rs2D, .RdD, .Funct3D, .Funct7D, .RegWriteD, .ALUSrcAD, .ALUSrcBD,
    .MemRWD, .ResultSrcD, .BranchD, .JumpD, .ALUResultSrcD, .ALUSelectD, .SubArithD,
    .MDUD, .CSRReadD, .CSRWriteD, .PrivilegedD, .FenceD, .InvalidateICacheD,
    .InstrValidD, .InstrValidE, .InstrValidM, .Rs1E, .Rs2E, .RdE, .RdM, .RdW, .PCSrcE,
    .ALUSrcAE, .ALUSrcBE, .ALUResultSrcE, .ALUSelectE, .Funct3E, .Funct7E, .SubArithE,
    .BranchE, .JumpE, .BranchSignedE, .MDUActiveE, .IntDivE, .ResultSrcE, .MemRWE,
    .MemRWM, .CSRReadE, .CSRReadM, .CSRWriteM, .PrivilegedM, .Funct3M,
    .InvalidateICacheM, .FlushDCacheM, .CSRWriteFenceM, .RegWriteM, .RegWriteW,
    .ResultSrcW, .IntDivW
  );

  hazardUnit hazard (
    .Rs1D, .Rs2D, .MemRWD, .Rs1E, .Rs2E, .RdE, .RdM, .RdW, .RegWriteM, .RegWriteW,
    .MemRWE, .ResultSrcE, .CSRReadE, .ForwardAE, .ForwardBE, .LoadStallD, .StoreStallD,
    .StructuralStallD
  );

endmodule

`default_nettype wire

// ==== test/ieuControllerChk.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ieuCtrl_defs.svh"

module ieuControllerChk (
  input logic             clk, rstN,
  input logic             FlushE, FlushM,
  input logic             InstrValidE, InstrValidM, RegWriteM,
  input logic [`REGW-1:0] RdE,
  input logic             PCSrcE, BranchE, JumpE
);

  //////////////////////////////////////////////////////////////////////
  // Flushed stages come back empty
  flushClearsE: assert property (@(posedge clk) disable iff (!rstN)
      FlushE |=> (!InstrValidE && (RdE == '0)))
    else $error("Execute stage holds data after a flush");

  flushClearsM: assert property (@(posedge clk) disable iff (!rstN)
      FlushM |=> (!InstrValidM && !RegWriteM))
    else $error("Memory stage holds data after a flush");

  // Redirect only from a control transfer
  pcSrcNeedsCtrl: assert property (@(posedge clk) disable iff (!rstN)
      PCSrcE |-> (BranchE || JumpE))
    else $error("PCSrcE set without branch or jump in Execute");

  resetEmptiesE: assert property (@(posedge clk) !rstN |=> !InstrValidE)
    else $error("InstrValidE set right after reset");

endmodule

`default_nettype wire

// ==== test/ieuControllerMon.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ieuCtrl_defs.svh"

module ieuControllerMon import ieuCtrlPkg::*; (
  input  immSrcE           ImmSrcD,
  input  logic             JumpD, BranchD, IllegalBaseInstrD,
  input  logic             LoadStallD, StoreStallD, StructuralStallD,
  input  logic             PCSrcE, InstrValidE,
  input  logic [1:0]       MemRWE,
  input  logic [`REGW-1:0] RdE,
  input  fwdSelE           ForwardAE, ForwardBE,
  input  logic             RegWriteM, CSRWriteM, CSRWriteFenceM, InvalidateICacheM,
  output int               testsRun, testsFailed, errorCount
);

  int testErrors;                                      // Errors in the running test

  initial begin
    testsRun    = 0;
    testsFailed = 0;
    errorCount  = 0;
    testErrors  = 0;
  end

  //////////////////////////////////////////////////////////////////////
  // Compare one watched DUT output with its expected value
  task automatic checkSig(input string name, input logic [7:0] exp);
    logic [7:0] got;
    logic       known;
    known = 1'b1;
    case (name)
      "ImmSrcD":           got = 8'(ImmSrcD);
      "JumpD":             got = 8'(JumpD);
      "BranchD":           got = 8'(BranchD);
      "IllegalBaseInstrD": got = 8'(IllegalBaseInstrD);
      "LoadStallD":        got = 8'(LoadStallD);
      "StoreStallD":       got = 8'(StoreStallD);
      "StructuralStallD":  got = 8'(StructuralStallD);
      "PCSrcE":            got = 8'(PCSrcE);
      "InstrValidE":       got = 8'(InstrValidE);
      "MemReadE":          got = 8'(MemRWE[1]);        // Read half of MemRWE
      "RdE":               got = 8'(RdE);
      "ForwardAE":         got = 8'(ForwardAE);
      "ForwardBE":         got = 8'(ForwardBE);
      "RegWriteM":         got = 8'(RegWriteM);
      "CSRWriteM":         got = 8'(CSRWriteM);
      "CSRWriteFenceM":    got = 8'(CSRWriteFenceM);
      "InvalidateICacheM": got = 8'(InvalidateICacheM);
      default: begin
        got   = 8'h00;
        known = 1'b0;
      end
    endcase
    if (!known) begin
      $display("ERROR: no watched signal is named %s", name);
      testErrors++;
    end else if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%02h, expected 0x%02h", name, got, exp);
      testErrors++;
    end
  endtask

  task automatic noteFailure(input string what);
    $display("ERROR: %s", what);
    testErrors++;
  endtask

  // One line per finished test
  task automatic closeTest(input string name);
    testsRun++;
    if (testErrors == 0) begin
      $display("test %-10s ok", name);
    end else begin
      $display("test %-10s failed with %0d errors", name, testErrors);
      testsFailed++;
      errorCount += testErrors;
    end
    testErrors = 0;
  endtask

endmodule

`default_nettype wire

// ==== test/ieuControllerTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ieuCtrl_defs.svh"

module ieuControllerTb import ieuCtrlPkg::*; ();

  localparam int NPAT = 19;                             // Lines in the pattern file
  localparam int TMO  = 10;                             // Edge limit of a wait
  localparam logic [`INSTRW-1:0] nopWord = 32'h00000013; // addi x0, x0, 0

  logic               clk, rstN;
  logic [`INSTRW-1:0] InstrD;
  logic               IllegalIEUInstrD;
  logic               StallD, StallE, StallM, StallW, FlushD, FlushE, FlushM, FlushW;
  logic [1:0]         FlagsE;                           // {eq, lt}
  immSrcE             ImmSrcD;
  logic               JumpD, BranchD, IllegalBaseInstrD, InstrValidD;
  logic               LoadStallD, StoreStallD, StructuralStallD;
  logic [`REGW-1:0]   Rs1D, Rs2D, Rs1E, Rs2E, RdE, RdM, RdW;
  logic               PCSrcE, ALUSrcAE, ALUSrcBE, ALUResultSrcE, SubArithE;
  logic               BranchE, JumpE, BranchSignedE, MDUActiveE, IntDivE, CSRReadE;
  logic               InstrValidE, CSRReadM, CSRWriteM, PrivilegedM, InstrValidM;
  logic               InvalidateICacheM, FlushDCacheM, CSRWriteFenceM;
  logic               RegWriteM, RegWriteW, IntDivW;
  logic [2:0]         ALUSelectE, Funct3E, Funct3M;
  logic [6:0]         Funct7E;
  resultSrcE          ResultSrcE, ResultSrcW;
  logic [1:0]         MemRWE, MemRWM;
  fwdSelE             ForwardAE, ForwardBE;
  int                 testsRun, testsFailed, errorCount;

  logic [59:0]        pats [0:NPAT-1];                  // Word and expected fields
  logic [31:0]        rng;
  logic [`REGW-1:0]   rdA, rdB, rsA, rsB;
  int                 edges;

  ieuController uut (.*);
  ieuControllerMon mon (.*);

  bind ctrlPipe ieuControllerChk chk (
    .clk(clk), .rstN(rstN), .FlushE(FlushE), .FlushM(FlushM), .InstrValidE(InstrValidE),
    .InstrValidM(InstrValidM), .RegWriteM(RegWriteM), .RdE(RdE), .PCSrcE(PCSrcE),
    .BranchE(BranchE), .JumpE(JumpE)
  );

  always #50 clk = ~clk;                                // 100 ns period

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] encode(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  // Newest producer wins, x0 stays on the register file
  function automatic fwdSelE fwdRule(input logic [4:0] rs, input logic [4:0] rdMem,
                                     input logic [4:0] rdWb);
    if (rs == 5'd0)    return fwdNone;
    if (rs == rdMem)   return fwdM;
    if (rs == rdWb)    return fwdW;
    return fwdNone;
  endfunction

  task automatic applyInstr(input logic [`INSTRW-1:0] word);
    @(posedge clk);
    #1;                                                 // Drive just after the edge
    InstrD = word;
  endtask

  task automatic waitWriteback(input logic [4:0] rd, output int count);
    count = 0;
    do begin
      applyInstr(nopWord);
      #20;
      count++;
    end while (!(RegWriteW && (RdW == rd)) && (count < TMO));
  endtask

  initial begin
    clk = 1'b0;
    rstN = 1'b0;
    InstrD = nopWord;
    IllegalIEUInstrD = 1'b0;
    {StallD, StallE, StallM, StallW} = 4'b0000;
    {FlushD, FlushE, FlushM, FlushW} = 4'b0000;
    FlagsE = 2'b00;
    rng = 32'd64;                                       // Seed
    $readmemh("test/ieuController_patterns.txt", pats);
    repeat (2) @(posedge clk);
    #1 rstN = 1'b1;

    ////////////////////////////////////////////////////////////////////
    // Decode and branch resolution from the pattern file
    if ($isunknown(pats[NPAT-1])) mon.noteFailure("pattern file is missing or too short");
    for (int i = 0; i <= NPAT; i++) begin
      applyInstr((i < NPAT) ? pats[i][59:28] : nopWord);
      if (i > 0) FlagsE = pats[i-1][5:4];               // Flags for the word in Execute
      #20;
      if (i < NPAT) begin
        mon.checkSig("ImmSrcD", 8'(pats[i][27:24]));
        mon.checkSig("JumpD", 8'(pats[i][23:20]));
        mon.checkSig("BranchD", 8'(pats[i][19:16]));
        mon.checkSig("IllegalBaseInstrD", 8'(pats[i][15:12]));
      end
      if (i > 0) begin
        mon.checkSig("MemReadE", 8'(pats[i-1][11:8]));
        mon.checkSig("PCSrcE", 8'(pats[i-1][3:0]));
      end
    end
    FlagsE = 2'b00;

    // A squashed word carries no controls at all
    applyInstr(32'h0000007F);                           // Unknown opcode
    IllegalIEUInstrD = 1'b1;
    #20;
    mon.checkSig("IllegalBaseInstrD", 8'd0);
    InstrD = 32'h010000EF;                              // jal x1, 16
    #20;
    mon.checkSig("JumpD", 8'd0);
    mon.checkSig("ImmSrcD", 8'(immI));
    IllegalIEUInstrD = 1'b0;
    InstrD = nopWord;
    mon.closeTest("decode");

    // add x9 must reach Writeback three edges after it is applied
    applyInstr(encode(7'd0, 5'd2, 5'd1, 3'd0, 5'd9, opReg));
    waitWriteback(5'd9, edges);
    if (!(RegWriteW && (RdW == 5'd9))) mon.noteFailure("timeout waiting for x9 in Writeback");
    else if (edges != 3) mon.noteFailure($sformatf("x9 reached Writeback after %0d edges", edges));
    mon.closeTest("timing");

    applyInstr(encode(7'd0, 5'd2, 5'd1, 3'd0, 5'd10, opReg)); // add x10
    FlushE = 1'b1;                                      // Squash it on its way to Execute
    applyInstr(nopWord);
    FlushE = 1'b0;
    #20;
    mon.checkSig("InstrValidE", 8'd0);
    mon.checkSig("RdE", 8'd0);
    applyInstr(nopWord);
    #20;
    mon.checkSig("RegWriteM", 8'd0);
    mon.closeTest("flush");

    ////////////////////////////////////////////////////////////////////
    // Forwarding with random pairs from x0..x3
    for (int k = 0; k < 8; k++) begin
      rng = xorshift(rng);
      rdA = {3'b000, rng[1:0]};
      rdB = {3'b000, rng[3:2]};
      rsA = {3'b000, rng[5:4]};
      rsB = {3'b000, rng[7:6]};
      applyInstr(encode(7'd0, 5'd0, 5'd0, 3'd0, rdA, opReg));
      applyInstr(encode(7'd0, 5'd0, 5'd0, 3'd0, rdB, opReg));
      applyInstr(encode(7'd0, rsB, rsA, 3'd0, 5'd0, opReg));
      applyInstr(nopWord);                              // Consumer now in Execute
      #20;
      mon.checkSig("ForwardAE", 8'(fwdRule(rsA, rdB, rdA)));
      mon.checkSig("ForwardBE", 8'(fwdRule(rsB, rdB, rdA)));
    end
    mon.closeTest("forwarding");

    applyInstr(encode(7'd0, 5'd0, 5'd6, 3'b010, 5'd5, opLoad));  // lw x5, 0(x6)
    applyInstr(encode(7'd0, 5'd0, 5'd5, 3'd0, 5'd7, opReg));     // add x7, x5, x0
    #20;
    mon.checkSig("LoadStallD", 8'd1);
    mon.checkSig("StructuralStallD", 8'd1);
    applyInstr(encode(7'd0, 5'd7, 5'd6, 3'b010, 5'd0, opStore)); // sw x7, 0(x6)
    applyInstr(encode(7'd0, 5'd0, 5'd6, 3'b010, 5'd8, opLoad));  // lw x8, 0(x6)
    #20;
    mon.checkSig("StoreStallD", 8'd1);
    applyInstr(encode(7'h18, 5'd0, 5'd0, 3'b010, 5'd5, opSystem)); // csrrs x5, mstatus, x0
    applyInstr(encode(7'd0, 5'd0, 5'd5, 3'd0, 5'd7, opReg));
    #20;
    mon.checkSig("LoadStallD", 8'd0);
    mon.checkSig("StructuralStallD", 8'd1);
    applyInstr(encode(7'd1, 5'd7, 5'd6, 3'd0, 5'd5, opReg));     // mul x5, x6, x7
    applyInstr(encode(7'd0, 5'd5, 5'd0, 3'd0, 5'd7, opReg));     // add x7, x0, x5
    #20;
    mon.checkSig("StructuralStallD", 8'd1);
    mon.closeTest("stalls");

    ////////////////////////////////////////////////////////////////////
    // Fence.i and CSR writes seen in Memory
    applyInstr(32'h0000100F);                           // fence.i
    applyInstr(nopWord);
    applyInstr(nopWord);
    #20;
    mon.checkSig("CSRWriteFenceM", 8'd1);
    mon.checkSig("InvalidateICacheM", 8'd1);
    applyInstr(encode(7'h18, 5'd0, 5'd0, 3'b010, 5'd5, opSystem)); // csrrs, source x0
    applyInstr(encode(7'h18, 5'd0, 5'd6, 3'b001, 5'd5, opSystem)); // csrrw, source x6
    applyInstr(nopWord);
    #20;
    mon.checkSig("CSRWriteM", 8'd0);
    applyInstr(nopWord);
    #20;
    mon.checkSig("CSRWriteM", 8'd1);
    mon.closeTest("fences");

    $display("tests %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
    if (testsFailed == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== ieuController.f ====
+incdir+verilog
verilog/ieuCtrlPkg.sv
verilog/instrDecoder.sv
verilog/ctrlPipe.sv
verilog/hazardUnit.sv
verilog/ieuController.sv
test/ieuControllerChk.sv
test/ieuControllerMon.sv
test/ieuControllerTb.sv

// ==== Makefile ====
# Verilator build and run of the IEU controller testbench
VERILATOR ?= verilator
TOP       ?= ieuControllerTb
FILELIST  ?= ieuController.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search $(LOG) for the result"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^RESULT: PASS$$" $(LOG) && echo "simulation passed" || \
	  (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/ieuController_patterns.txt ====
// Columns: instr[59:28] immSrc[27:24] jump[23:20] branch[19:16] illegal[15:12]
//          memRead[11:8] flags {eq,lt}[7:4] pcSrcE[3:0], one hex digit per field
003100B30000000  // add x1, x2, x3
407302B30000000  // sub x5, x6, x7
407312B30001000  // sll with funct7 0x20 is illegal
027302B30000000  // mul x5, x6, x7
004120830000100  // lw x1, 4(x2)
003124231000000  // sw x3, 8(x2)
002084632010021  // beq, eq set, taken
002094632010020  // bne, eq set, not taken
0020C4632010011  // blt, lt set, taken
0020F4632010010  // bgeu, lt set, not taken
0020F4632010001  // bgeu, flags clear, taken
0020A4630001000  // branch funct3 010 is illegal
010000EF3100001  // jal x1, 16
010000EF3100031  // jal with both flags set
000100E70100001  // jalr x1, 0(x2)
123452B74000000  // lui x5, 0x12345
0000100F0000000  // fence.i
300110F30000000  // csrrw x1, mstatus, x2
0000007F0001000  // unknown opcode
